// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= ctrlTb
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ns
PASS_TEXT ?= TEST PASSED

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS PASS_TEXT"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)

// ==== files.f ====
+incdir+tb
src/ctrlPkg.sv
src/instrDecoder.sv
src/ctrlSequencer.sv
src/ctrlSignalGen.sv
src/ctrlTop.sv
tb/ctrlTb.sv

// ==== src/ctrlPkg.sv ====
`default_nettype none

package ctrlPkg;

    // ------------------------------------------------------------------------
    // field widths and fetch timing
    // ------------------------------------------------------------------------
    localparam int opcodeWidth = 6;
    localparam int functWidth  = 6;
    localparam int stepWidth   = 2;

    // memory wait steps before the instruction register loads
    localparam logic [stepWidth-1:0] fetchSteps = 2'd3;

    // ------------------------------------------------------------------------
    // opcodes and funct codes of the kept instruction set
    // ------------------------------------------------------------------------
    localparam logic [opcodeWidth-1:0] opcRType = 6'h00; // funct selects the op
    localparam logic [opcodeWidth-1:0] opcAddi  = 6'h08;
    localparam logic [opcodeWidth-1:0] opcBeq   = 6'h04;
    localparam logic [opcodeWidth-1:0] opcBne   = 6'h05;
    localparam logic [opcodeWidth-1:0] opcBle   = 6'h06;
    localparam logic [opcodeWidth-1:0] opcBgt   = 6'h07;
    localparam logic [opcodeWidth-1:0] opcJ     = 6'h02;
    localparam logic [opcodeWidth-1:0] opcJal   = 6'h03;

    localparam logic [functWidth-1:0] fnAdd  = 6'h20;
    localparam logic [functWidth-1:0] fnAnd  = 6'h24;
    localparam logic [functWidth-1:0] fnSub  = 6'h22;
    localparam logic [functWidth-1:0] fnJr   = 6'h08;
    localparam logic [functWidth-1:0] fnMfhi = 6'h10;
    localparam logic [functWidth-1:0] fnMflo = 6'h12;

    // ------------------------------------------------------------------------
    // datapath control encodings
    // ------------------------------------------------------------------------
    localparam logic [2:0] aluPass = 3'b000; // a passes straight through
    localparam logic [2:0] aluAdd  = 3'b001;
    localparam logic [2:0] aluSub  = 3'b010;
    localparam logic [2:0] aluAnd  = 3'b011;
    localparam logic [2:0] aluCmp  = 3'b111; // sets eq, gt, lt

    localparam logic [1:0] regDstRt = 2'b00;
    localparam logic [1:0] regDstSp = 2'b01;
    localparam logic [1:0] regDstRa = 2'b10;
    localparam logic [1:0] regDstRd = 2'b11;

    localparam logic [2:0] memToRegAlu    = 3'b000;
    localparam logic [2:0] memToRegHi     = 3'b010;
    localparam logic [2:0] memToRegLo     = 3'b011;
    localparam logic [2:0] memToRegSpInit = 3'b111; // stack pointer start value

    localparam logic [1:0] aluSrcBReg    = 2'b00;
    localparam logic [1:0] aluSrcBFour   = 2'b01;
    localparam logic [1:0] aluSrcBImm    = 2'b10;
    localparam logic [1:0] aluSrcBBranch = 2'b11; // shifted offset for target

    localparam logic [2:0] pcSrcAlu    = 3'b000;
    localparam logic [2:0] pcSrcBranch = 3'b001;
    localparam logic [2:0] pcSrcJump   = 3'b010;

    // decoded operation class
    typedef enum logic [3:0] {
        opAdd, opAnd, opSub, opJr, opMfhi, opMflo, opAddi,
        opBeq, opBne, opBle, opBgt, opJ, opJal, opNone
    } opClass_e;

    typedef enum logic [1:0] {
        stFetch, stDecode, stExec
    } ctrlState_e;

    typedef struct packed {
        logic [4:0]            rd;
        logic [4:0]            shamt;
        logic [functWidth-1:0] funct;
    } rFields_t;

    // low half of the instruction, r-format fields or i-format immediate
    typedef union packed {
        rFields_t    rView;
        logic [15:0] iView;
    } instrLow_u;

endpackage

`default_nettype wire

// ==== src/ctrlSequencer.sv ====
`timescale 1ns/1ns
`default_nettype none

module ctrlSequencer import ctrlPkg::*; (
    input  wire logic           clk,
    input  wire logic           reset,
    input  wire opClass_e       opClass,
    output ctrlState_e          state,
    output logic [stepWidth-1:0] step,
    output opClass_e            execClass
);

    // single-cycle classes finish on step 0, the rest on step 1
    function automatic logic [stepWidth-1:0] execLastStep(opClass_e cls);
        case (cls)
            opJr, opMfhi, opMflo, opJ: return '0;
            default:                   return stepWidth'(1);
        endcase
    endfunction

    // ------------------------------------------------------------------------
    // state and step counter
    // ------------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            state     <= stFetch;
            step      <= '0;
            execClass <= opNone;
        end else begin
            case (state)
                stFetch: begin
                    if (step == fetchSteps) begin // ir loads on this step
                        state <= stDecode;
                        step  <= '0;
                    end else begin
                        step <= step + 1'b1;
                    end
                end
                stDecode: begin
                    if (step == '0) begin
                        step <= step + 1'b1;
                    end else begin
                        step      <= '0;
                        execClass <= opClass; // ir is stable by now
                        state     <= (opClass == opNone) ? stFetch : stExec;
                    end
                end
                stExec: begin
                    if (step == execLastStep(execClass)) begin
                        state <= stFetch;
                        step  <= '0;
                    end else begin
                        step <= step + 1'b1;
                    end
                end
                default: begin
                    state <= stFetch;
                    step  <= '0;
                end
            endcase
        end
    end

    // decode and execute never go past step 1
    stepRange: assert property (@(posedge clk) disable iff (reset)
        (state == stFetch) ? (step <= fetchSteps) : (step <= stepWidth'(1)));

    execKnown: assert property (@(posedge clk) disable iff (reset)
        (state == stExec) |-> (execClass != opNone));

endmodule

`default_nettype wire

// ==== src/ctrlSignalGen.sv ====
`timescale 1ns/1ns
`default_nettype none

module ctrlSignalGen import ctrlPkg::*; (
    input  wire logic                 clk,
    input  wire logic                 reset,
    input  wire ctrlState_e           state,
    input  wire logic [stepWidth-1:0] step,
    input  wire opClass_e             execClass,
    input  wire logic                 eq,
    input  wire logic                 gt,
    input  wire logic                 lt,
    output logic                      pcWrite,
    output logic                      irWrite,
    output logic                      regWrite,
    output logic                      aWrite,
    output logic                      bWrite,
    output logic                      aluOutWrite,
    output logic [1:0]                regDst,
    output logic [2:0]                memToReg,
    output logic                      aluSrcA,
    output logic [1:0]                aluSrcB,
    output logic [2:0]                aluOp,
    output logic [2:0]                pcSource
);

    logic       branchTaken;
    logic [2:0] arithOp;

    // flags come from the compare done in execute step 0
    always_comb begin
        case (execClass)
            opBeq:   branchTaken = eq;
            opBne:   branchTaken = !eq;
            opBle:   branchTaken = eq || lt;
            opBgt:   branchTaken = gt;
            default: branchTaken = 1'b0;
        endcase
    end

    assign arithOp = (execClass == opAnd) ? aluAnd :
                     (execClass == opSub) ? aluSub : aluAdd;

    // ------------------------------------------------------------------------
    // registered outputs, enables pulse for one cycle, selects hold
    // ------------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            pcWrite     <= 1'b0;
            irWrite     <= 1'b0;
            regWrite    <= 1'b1; // loads the stack pointer during reset
            aWrite      <= 1'b0;
            bWrite      <= 1'b0;
            aluOutWrite <= 1'b0;
            regDst      <= regDstSp;
            memToReg    <= memToRegSpInit;
            aluSrcA     <= 1'b0;
            aluSrcB     <= aluSrcBReg;
            aluOp       <= aluPass;
            pcSource    <= pcSrcAlu;
        end else begin
            pcWrite     <= 1'b0;
            irWrite     <= 1'b0;
            regWrite    <= 1'b0;
            aWrite      <= 1'b0;
            bWrite      <= 1'b0;
            aluOutWrite <= 1'b0;
            case (state)
                stFetch: begin
                    if (step < fetchSteps) begin // pc + 4 while memory answers
                        aluSrcA     <= 1'b0;
                        aluSrcB     <= aluSrcBFour;
                        aluOp       <= aluAdd;
                        pcSource    <= pcSrcAlu;
                        aluOutWrite <= 1'b1;
                    end else begin
                        pcWrite <= 1'b1;
                        irWrite <= 1'b1;
                    end
                end
                stDecode: begin
                    if (step == '0) begin
                        aluSrcB     <= aluSrcBBranch; // branch target ahead of time
                        aluOp       <= aluAdd;
                        aluOutWrite <= 1'b1;
                    end else begin
                        aWrite <= 1'b1;
                        bWrite <= 1'b1;
                    end
                end
                stExec: begin
                    case (execClass)
                        opAdd, opAnd, opSub, opAddi: begin
                            if (step == '0) begin
                                aluSrcA     <= 1'b1;
                                aluSrcB     <= (execClass == opAddi) ? aluSrcBImm : aluSrcBReg;
                                aluOp       <= arithOp;
                                aluOutWrite <= 1'b1;
                            end else begin
                                regWrite <= 1'b1;
                                regDst   <= (execClass == opAddi) ? regDstRt : regDstRd;
                                memToReg <= memToRegAlu;
                            end
                        end
                        opBeq, opBne, opBle, opBgt: begin
                            if (step == '0) begin
                                aluSrcA <= 1'b1;
                                aluSrcB <= aluSrcBReg;
                                aluOp   <= aluCmp;
                            end else if (branchTaken) begin
                                pcWrite  <= 1'b1;
                                pcSource <= pcSrcBranch;
                            end
                        end
                        opJr: begin
                            aluOp    <= aluPass; // rs straight to pc
                            pcSource <= pcSrcAlu;
                            pcWrite  <= 1'b1;
                        end
                        opMfhi, opMflo: begin
                            regWrite <= 1'b1;
                            regDst   <= regDstRd;
                            memToReg <= (execClass == opMfhi) ? memToRegHi : memToRegLo;
                        end
                        opJ: begin
                            pcSource <= pcSrcJump;
                            pcWrite  <= 1'b1;
                        end
                        opJal: begin
                            if (step == '0) begin // save return address
                                aluSrcA     <= 1'b0;
                                aluOp       <= aluPass;
                                aluOutWrite <= 1'b1;
                            end else begin
                                pcWrite  <= 1'b1;
                                pcSource <= pcSrcJump;
                                regWrite <= 1'b1;
                                regDst   <= regDstRa;
                                memToReg <= memToRegAlu;
                            end
                        end
                        default: ;
                    endcase
                end
                default: ;
            endcase
        end
    end

    noIrRegOverlap: assert property (@(posedge clk) disable iff (reset)
        !(irWrite && regWrite));

    // pc update only from the ir load step or from execute
    pcWriteSource: assert property (@(posedge clk) disable iff (reset)
        $rose(pcWrite) |-> ($past(state) == stExec) ||
                           ($past(state) == stFetch && $past(step) == fetchSteps));

endmodule

`default_nettype wire

// ==== src/ctrlTop.sv ====
`timescale 1ns/1ns
`default_nettype none

module ctrlTop import ctrlPkg::*; (
    input  wire logic                   clk,
    input  wire logic                   reset,
    input  wire logic [opcodeWidth-1:0] opcode,
    input  wire instrLow_u              instrLow,
    input  wire logic                   eq,
    input  wire logic                   gt,
    input  wire logic                   lt,
    output logic                        pcWrite,
    output logic                        irWrite,
    output logic                        regWrite,
    output logic                        aWrite,
    output logic                        bWrite,
    output logic                        aluOutWrite,
    output logic [1:0]                  regDst,
    output logic [2:0]                  memToReg,
    output logic                        aluSrcA,
    output logic [1:0]                  aluSrcB,
    output logic [2:0]                  aluOp,
    output logic [2:0]                  pcSource
);

    opClass_e             opClass;   // straight from the ir fields
    opClass_e             execClass; // held through execute
    ctrlState_e           state;
    logic [stepWidth-1:0] step;

    instrDecoder u_instrDecoder (
        .opcode   (opcode),
        .instrLow (instrLow),
        .opClass  (opClass)
    );

    ctrlSequencer u_ctrlSequencer (
        .clk       (clk),
        .reset     (reset),
        .opClass   (opClass),
        .state     (state),
        .step      (step),
        .execClass (execClass)
    );

    ctrlSignalGen u_ctrlSignalGen (
        .clk         (clk),
        .reset       (reset),
        .state       (state),
        .step        (step),
        .execClass   (execClass),
        .eq          (eq),
        .gt          (gt),
        .lt          (lt),
        .pcWrite     (pcWrite),
        .irWrite     (irWrite),
        .regWrite    (regWrite),
        .aWrite      (aWrite),
        .bWrite      (bWrite),
        .aluOutWrite (aluOutWrite),
        .regDst      (regDst),
        .memToReg    (memToReg),
        .aluSrcA     (aluSrcA),
        .aluSrcB     (aluSrcB),
        .aluOp       (aluOp),
        .pcSource    (pcSource)
    );

endmodule

`default_nettype wire

// ==== src/instrDecoder.sv ====
`timescale 1ns/1ns
`default_nettype none

module instrDecoder import ctrlPkg::*; (
    input  wire logic [opcodeWidth-1:0] opcode,
    input  wire instrLow_u              instrLow,
    output opClass_e                    opClass
);

    logic [functWidth-1:0] funct;

    assign funct = instrLow.rView.funct;

    // ------------------------------------------------------------------------
    // opcode first, funct only for r-format
    // ------------------------------------------------------------------------
    always_comb begin
        opClass = opNone; // anything unknown falls back to fetch
        case (opcode)
            opcRType: begin
                case (funct)
                    fnAdd:   opClass = opAdd;
                    fnAnd:   opClass = opAnd;
                    fnSub:   opClass = opSub;
                    fnJr:    opClass = opJr;
                    fnMfhi:  opClass = opMfhi;
                    fnMflo:  opClass = opMflo;
                    default: opClass = opNone;
                endcase
            end
            opcAddi: opClass = opAddi;
            opcBeq:  opClass = opBeq;
            opcBne:  opClass = opBne;
            opcBle:  opClass = opBle;
            opcBgt:  opClass = opBgt;
            opcJ:    opClass = opJ;
            opcJal:  opClass = opJal;
            default: opClass = opNone;
        endcase
    end

endmodule

`default_nettype wire

// ==== tb/ctrlModel.svh ====
`ifndef ctrlModelSvh
`define ctrlModelSvh

`default_nettype none

// what one instruction should do between two irWrite pulses
typedef struct {
    int         cycles;       // irWrite to next irWrite
    int         eventCycle;   // cycle of the execute write pulse
    bit         regWr;
    logic [1:0] regDst;
    logic [2:0] memToReg;
    bit         aluChk;       // arithmetic classes only
    logic [2:0] aluOp;
    bit         pcWr;
    logic [2:0] pcSrc;
    int         aluOutWrites; // every aluOutWrite pulse of the period
    bit         srcChk;       // two-step executes only
    logic       aluSrcA;
    logic [1:0] aluSrcB;
} expectation_t;

// ---------------------------------------------------------------------------
// reference behaviour per instruction
// ---------------------------------------------------------------------------
function automatic expectation_t expectedBehaviour(
    input logic [5:0] opcode,
    input logic [5:0] funct,
    input logic       eq,
    input logic       gt,
    input logic       lt
);
    expectation_t e;
    int           execLen;
    e = '{default: 0};
    execLen = 0; // unknown goes straight back to fetch
    case (opcode)
        ctrlPkg::opcRType: begin
            case (funct)
                ctrlPkg::fnAdd, ctrlPkg::fnAnd, ctrlPkg::fnSub: begin
                    execLen    = 2;
                    e.regWr    = 1'b1;
                    e.regDst   = ctrlPkg::regDstRd;
                    e.memToReg = ctrlPkg::memToRegAlu;
                    e.aluChk   = 1'b1;
                    e.aluOp    = (funct == ctrlPkg::fnAdd) ? ctrlPkg::aluAdd :
                                 (funct == ctrlPkg::fnAnd) ? ctrlPkg::aluAnd : ctrlPkg::aluSub;
                    e.srcChk   = 1'b1;
                    e.aluSrcA  = 1'b1;
                    e.aluSrcB  = ctrlPkg::aluSrcBReg;
                end
                ctrlPkg::fnJr: begin
                    execLen = 1;
                    e.pcWr  = 1'b1;
                    e.pcSrc = ctrlPkg::pcSrcAlu;
                end
                ctrlPkg::fnMfhi, ctrlPkg::fnMflo: begin
                    execLen    = 1;
                    e.regWr    = 1'b1;
                    e.regDst   = ctrlPkg::regDstRd;
                    e.memToReg = (funct == ctrlPkg::fnMfhi) ? ctrlPkg::memToRegHi
                                                            : ctrlPkg::memToRegLo;
                end
                default: ;
            endcase
        end
        ctrlPkg::opcAddi: begin
            execLen    = 2;
            e.regWr    = 1'b1;
            e.regDst   = ctrlPkg::regDstRt; // i-format writes rt
            e.memToReg = ctrlPkg::memToRegAlu;
            e.aluChk   = 1'b1;
            e.aluOp    = ctrlPkg::aluAdd;
            e.srcChk   = 1'b1;
            e.aluSrcA  = 1'b1;
            e.aluSrcB  = ctrlPkg::aluSrcBImm;
        end
        ctrlPkg::opcBeq, ctrlPkg::opcBne, ctrlPkg::opcBle, ctrlPkg::opcBgt: begin
            execLen   = 2;
            e.pcSrc   = ctrlPkg::pcSrcBranch;
            e.srcChk  = 1'b1;
            e.aluSrcA = 1'b1;
            e.aluSrcB = ctrlPkg::aluSrcBReg;
            case (opcode)
                ctrlPkg::opcBeq: e.pcWr = eq;
                ctrlPkg::opcBne: e.pcWr = !eq;
                ctrlPkg::opcBle: e.pcWr = eq || lt;
                default:         e.pcWr = gt;
            endcase
        end
        ctrlPkg::opcJ: begin
            execLen = 1;
            e.pcWr  = 1'b1;
            e.pcSrc = ctrlPkg::pcSrcJump;
        end
        ctrlPkg::opcJal: begin
            execLen    = 2; // link and jump land together
            e.pcWr     = 1'b1;
            e.pcSrc    = ctrlPkg::pcSrcJump;
            e.regWr    = 1'b1;
            e.regDst   = ctrlPkg::regDstRa;
            e.memToReg = ctrlPkg::memToRegAlu;
            e.srcChk   = 1'b1;
            e.aluSrcA  = 1'b0;
            e.aluSrcB  = ctrlPkg::aluSrcBBranch; // b select left over from decode
        end
        default: ;
    endcase
    e.cycles       = 6 + execLen; // four fetch plus two decode
    e.eventCycle   = 2 + execLen;
    e.aluOutWrites = (e.regWr && execLen == 2) ? 5 : 4; // three fetch and one decode pulse
    return e;
endfunction

// galois lfsr with taps for x^32 + x^22 + x^2 + x + 1
function automatic logic [31:0] lfsrStep(input logic [31:0] s);
    logic [31:0] n;
    n = s >> 1;
    if (s[0]) begin
        n = n ^ 32'h80200003;
    end
    return n;
endfunction

`default_nettype wire

`endif

// ==== tb/ctrlTb.sv ====
`timescale 1ns/1ns
`include "ctrlModel.svh"
`default_nettype none

module ctrlTb import ctrlPkg::*; ();

    localparam int clkPeriod      = 20;
    localparam int driveDelay     = 2;
    localparam int resetCycles    = 3;
    localparam int numKinds       = 16;
    localparam int numInstr       = 48;
    localparam int watchdogCycles = resetCycles + numInstr * 12;

    logic                   clk = 1'b0;
    logic                   reset;
    logic [opcodeWidth-1:0] opcode;
    instrLow_u              instrLow;
    logic                   eq, gt, lt;
    logic                   pcWrite, irWrite, regWrite, aWrite, bWrite, aluOutWrite;
    logic [1:0]             regDst, aluSrcB;
    logic [2:0]             memToReg, aluOp, pcSource;
    logic                   aluSrcA;

    logic [31:0] lfsr;
    int          kindQ [$];
    logic [2:0]  flagQ [$]; // eq, gt, lt
    int          errorCount = 0;
    int          testErrors = 0;
    int          testsRun = 0;
    int          testsFailed = 0;
    int          checkedCount = 0;

    // instruction mix with three unknown kinds at the end
    logic [opcodeWidth-1:0] kindOp [numKinds] = '{opcRType, opcRType, opcRType, opcAddi,
        opcBeq, opcBne, opcBle, opcBgt, opcJ, opcRType, opcRType, opcRType, opcJal,
        6'h23, 6'h3f, opcRType};
    logic [functWidth-1:0] kindFn [numKinds] = '{fnAdd, fnAnd, fnSub, 6'h00,
        6'h00, 6'h00, 6'h00, 6'h00, 6'h00, fnJr, fnMfhi, fnMflo, 6'h00,
        6'h00, 6'h00, 6'h1a};
    string kindNames [numKinds] = '{"ADD", "AND", "SUB", "ADDI", "BEQ", "BNE", "BLE",
        "BGT", "J", "JR", "MFHI", "MFLO", "JAL", "op23", "op3f", "fn1a"};

    ctrlTop u_ctrlTop (
        .clk (clk), .reset (reset), .opcode (opcode), .instrLow (instrLow),
        .eq (eq), .gt (gt), .lt (lt),
        .pcWrite (pcWrite), .irWrite (irWrite), .regWrite (regWrite),
        .aWrite (aWrite), .bWrite (bWrite), .aluOutWrite (aluOutWrite),
        .regDst (regDst), .memToReg (memToReg), .aluSrcA (aluSrcA),
        .aluSrcB (aluSrcB), .aluOp (aluOp), .pcSource (pcSource)
    );

    always #(clkPeriod / 2) clk = ~clk;

    task automatic takeRandomBits(input int count, output logic [31:0] value);
        value = '0;
        for (int i = 0; i < count; i++) begin
            lfsr  = lfsrStep(lfsr); // one step per bit
            value = {value[30:0], lfsr[0]};
        end
    endtask

    task automatic checkValue(input string name, input logic [31:0] got,
                              input logic [31:0] want);
        assert (got === want) else begin
            $display("FAIL %s: got 0x%0h, expected 0x%0h", name, got, want);
            errorCount++;
            testErrors++;
        end
    endtask

    task automatic finishTest(input string label);
        testsRun++;
        if (testErrors != 0) begin
            testsFailed++;
        end
        $display("%s  %s", (testErrors == 0) ? "pass" : "fail", label);
        testErrors = 0;
    endtask

    // ------------------------------------------------------------------------
    // stimulus presents the next instruction right after each ir load
    // ------------------------------------------------------------------------
    initial begin
        logic [31:0] bits;
        int          kind;
        reset    = 1'b1;
        opcode   = '0;
        instrLow = '0;
        eq       = 1'b0;
        gt       = 1'b0;
        lt       = 1'b0;
        lfsr     = 32'h2759;
        repeat (resetCycles) @(posedge clk);
        #driveDelay reset = 1'b0;
        for (int i = 0; i < numInstr; i++) begin
            @(posedge clk);
            #driveDelay;
            while (irWrite !== 1'b1) begin
                @(posedge clk);
                #driveDelay;
            end
            kind   = i % numKinds;
            opcode = kindOp[kind];
            if (kindOp[kind] == opcRType) begin
                takeRandomBits(5, bits);
                instrLow.rView.rd    = bits[4:0];
                instrLow.rView.shamt = '0;
                instrLow.rView.funct = kindFn[kind];
            end else begin
                takeRandomBits(16, bits);
                instrLow.iView = bits[15:0]; // immediate or jump target bits
            end
            takeRandomBits(3, bits);
            {eq, gt, lt} = bits[2:0]; // held until the next instruction
            kindQ.push_back(kind);
            flagQ.push_back(bits[2:0]);
        end
        wait (checkedCount == numInstr);
        $display("tests %0d, passed %0d, failed %0d, errors %0d",
                 testsRun, testsRun - testsFailed, testsFailed, errorCount);
        if (errorCount == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    // ------------------------------------------------------------------------
    // compare process samples outputs on the falling edge
    // ------------------------------------------------------------------------
    initial begin
        int           cycles, regCount, pcCount, regCycle, pcCycle, kind;
        int           aCount, bCount, aCycle, bCycle, aluOutCount;
        logic [1:0]   dstSeen, srcBSeen;
        logic         srcASeen;
        logic [2:0]   memSeen, aluSeen, pcSrcSeen, prevAluOp, flags;
        expectation_t model;
        @(negedge clk);
        while (reset === 1'b1) begin
            checkValue("regWrite", 32'(regWrite), 32'd1);
            checkValue("regDst", 32'(regDst), 32'(regDstSp));
            checkValue("memToReg", 32'(memToReg), 32'(memToRegSpInit));
            checkValue("pcWrite", 32'(pcWrite), 32'd0);
            checkValue("irWrite", 32'(irWrite), 32'd0);
            @(negedge clk);
        end
        cycles = 0; // this sample still shows the last reset edge
        do begin
            @(negedge clk);
            cycles++;
            checkValue("regWrite", 32'(regWrite), 32'd0);
        end while (irWrite !== 1'b1 && cycles < 8);
        checkValue("first irWrite cycle", cycles, 32'd4);
        finishTest("reset and first fetch");
        for (int n = 0; n < numInstr; n++) begin
            kind        = kindQ.pop_front();
            flags       = flagQ.pop_front();
            cycles      = 0;
            regCount    = 0;
            pcCount     = 0;
            regCycle    = 0;
            pcCycle     = 0;
            aCount      = 0;
            bCount      = 0;
            aCycle      = 0;
            bCycle      = 0;
            aluOutCount = 0;
            dstSeen     = '0;
            srcASeen    = '0;
            srcBSeen    = '0;
            memSeen     = '0;
            aluSeen     = '0;
            pcSrcSeen   = '0;
            prevAluOp   = aluOp;
            do begin
                @(negedge clk);
                cycles++;
                if (regWrite === 1'b1) begin
                    regCount++;
                    regCycle = cycles;
                    dstSeen  = regDst;
                    memSeen  = memToReg;
                    aluSeen  = prevAluOp;
                end
                if (pcWrite === 1'b1 && irWrite !== 1'b1) begin // skip the fetch pc update
                    pcCount++;
                    pcCycle   = cycles;
                    pcSrcSeen = pcSource;
                end
                if (aWrite === 1'b1) begin
                    aCount++;
                    aCycle = cycles;
                end
                if (bWrite === 1'b1) begin
                    bCount++;
                    bCycle = cycles;
                end
                if (aluOutWrite === 1'b1) begin
                    aluOutCount++;
                end
                if (cycles == 1) begin // branch target from decode step 0
                    checkValue("aluSrcB", 32'(aluSrcB), 32'(aluSrcBBranch));
                end
                if (cycles == 3) begin
                    srcASeen = aluSrcA;
                    srcBSeen = aluSrcB;
                end
                prevAluOp = aluOp;
            end while (irWrite !== 1'b1 && cycles < 16);
            model = expectedBehaviour(kindOp[kind], kindFn[kind], flags[2], flags[1], flags[0]);
            checkValue("cycles", cycles, model.cycles);
            checkValue("regWrite pulses", regCount, 32'(model.regWr));
            checkValue("execute pcWrite pulses", pcCount, 32'(model.pcWr));
            checkValue("aWrite pulses", aCount, 32'd1);
            checkValue("bWrite pulses", bCount, 32'd1);
            checkValue("aWrite cycle", aCycle, 32'd2);
            checkValue("bWrite cycle", bCycle, 32'd2);
            checkValue("aluOutWrite pulses", aluOutCount, model.aluOutWrites);
            checkValue("aluSrcA", 32'(aluSrcA), 32'd0); // pc + 4 selects from fetch
            checkValue("aluSrcB", 32'(aluSrcB), 32'(aluSrcBFour));
            if (model.srcChk) begin
                checkValue("aluSrcA", 32'(srcASeen), 32'(model.aluSrcA));
                checkValue("aluSrcB", 32'(srcBSeen), 32'(model.aluSrcB));
            end
            if (model.regWr && regCount == 1) begin
                checkValue("regWrite cycle", regCycle, model.eventCycle);
                checkValue("regDst", 32'(dstSeen), 32'(model.regDst));
                checkValue("memToReg", 32'(memSeen), 32'(model.memToReg));
                if (model.aluChk) begin
                    checkValue("aluOp", 32'(aluSeen), 32'(model.aluOp));
                end
            end
            if (model.pcWr && pcCount == 1) begin
                checkValue("pcWrite cycle", pcCycle, model.eventCycle);
                checkValue("pcSource", 32'(pcSrcSeen), 32'(model.pcSrc));
            end
            finishTest($sformatf("instr %0d %s flags %b", n, kindNames[kind], flags));
            checkedCount++;
        end
    end

    initial begin
        #(watchdogCycles * clkPeriod);
        $display("watchdog expired before all instructions were checked");
        $display("TEST FAILED");
        $finish;
    end

endmodule

`default_nettype wire
